/* hw/usb_stream_params.svh */
`ifndef USB_STREAM_PARAMS_SVH
`define USB_STREAM_PARAMS_SVH

// ==================================================
// Data path widths
// ==================================================
`define PIXEL_W 16              // Camera word, RGB565
`define BYTE_W 8                // ULPI and transmit byte

// ==================================================
// Buffering and packet framing
// ==================================================
`define FIFO_DEPTH_BYTES 1024   // Power of two, >= 2 packets
`define PKT_LEN 512             // High-speed bulk max packet
`define CNT_W 11                // Holds 0 .. FIFO_DEPTH_BYTES

// ==================================================
// Misc constants
// ==================================================
`define HEARTBEAT_HALF_PERIOD 30000000  // Half second at 60 MHz
`define TX_ISO_PID 4'b0011      // DATA0

`endif

/* hw/usb_stream_pkg.sv */
`default_nettype none

`include "usb_stream_params.svh"

package usb_stream_pkg;

  // ==================================================
  // Payload types
  // ==================================================
  typedef logic [`PIXEL_W-1:0] pixel_t;     // One camera pixel
  typedef logic [`BYTE_W-1:0] byte_t;       // One ULPI or transmit byte

  // Fill level of the byte FIFO
  typedef logic [`CNT_W-1:0] fifo_count_t;  // Bytes waiting

  // ==================================================
  // Packet FSM
  // ==================================================
  typedef enum logic {
    STREAM_IDLE = 1'b0,                     // Waiting for a full packet
    STREAM_SEND = 1'b1                      // Packet in progress
  } stream_state_t;

endpackage

`default_nettype wire

/* hw/pixel_byte_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

`include "usb_stream_params.svh"

module pixel_byte_fifo
  import usb_stream_pkg::*;
(
  input  wire         ulpi_clk,       // Single clock domain
  input  wire         I_rst_n,        // Async, active low
  input  wire         wr_en_i,        // Pixel strobe
  input  wire pixel_t wr_data_i,      // Pixel word
  input  wire         rd_en_i,        // Pop head byte
  output byte_t       rd_data_o,      // Head byte, FWFT
  output fifo_count_t count_o,        // Bytes stored
  output logic        almost_full_o   // Less than two bytes free
);

  // ==================================================
  // Geometry
  // ==================================================
  localparam int DEPTH = `FIFO_DEPTH_BYTES;
  localparam int ADDR_W = $clog2(DEPTH);
  localparam fifo_count_t DEPTH_C = fifo_count_t'(DEPTH);
  localparam fifo_count_t ONE_C = fifo_count_t'(1);
  localparam fifo_count_t TWO_C = fifo_count_t'(2);

  byte_t             mem [DEPTH];     // Byte storage
  logic [ADDR_W-1:0] wr_ptr_q;        // Next free slot, always even
  logic [ADDR_W-1:0] rd_ptr_q;        // Head slot
  logic [ADDR_W-1:0] wr_ptr_odd;      // Slot for the low byte
  fifo_count_t       count_q;         // Fill level
  logic              wr_go;           // Accepted write

  // Room check covers both halves of the pixel
  assign almost_full_o = (DEPTH_C - count_q) < TWO_C;
  assign wr_go = wr_en_i && !almost_full_o;       // Drop pixel when no room
  assign wr_ptr_odd = wr_ptr_q + ADDR_W'(1);      // Wraps with the pointer

  // ==================================================
  // Storage
  // ==================================================
  always_ff @(posedge ulpi_clk) begin
    if (wr_go) begin
      mem[wr_ptr_q] <= wr_data_i[`PIXEL_W-1 -: `BYTE_W];  // High byte first
      mem[wr_ptr_odd] <= wr_data_i[`BYTE_W-1:0];           // Then low byte
    end
  end

  // Head shows without a read strobe
  assign rd_data_o = mem[rd_ptr_q];

  // ==================================================
  // Pointers and fill level
  // ==================================================
  always_ff @(posedge ulpi_clk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q <= '0;
    end else begin
      if (wr_go) begin
        wr_ptr_q <= wr_ptr_q + ADDR_W'(2);    // Two bytes per pixel
      end
      if (rd_en_i) begin
        rd_ptr_q <= rd_ptr_q + ADDR_W'(1);    // One byte per pop
      end
      case ({wr_go, rd_en_i})
        2'b10: begin
          count_q <= count_q + TWO_C;         // Write only
        end
        2'b01: begin
          count_q <= count_q - ONE_C;         // Read only
        end
        2'b11: begin
          count_q <= count_q + ONE_C;         // Net gain of one
        end
        default: begin
          count_q <= count_q;                 // Idle
        end
      endcase
    end
  end

  assign count_o = count_q;

  // ==================================================
  // Checks
  // ==================================================
  // The streamer qualifies pops, so an empty read means its gating broke
  a_no_read_empty: assert property (
    @(posedge ulpi_clk) disable iff (!I_rst_n)
    rd_en_i |-> (count_q != '0)
  ) else $error("FIFO read at zero fill");

  // Fill level stays in range across any mix of writes and pops
  a_count_bound: assert property (
    @(posedge ulpi_clk) disable iff (!I_rst_n)
    count_q <= DEPTH_C
  ) else $error("FIFO fill beyond depth");

endmodule

`default_nettype wire

/* hw/packet_streamer.sv */
`timescale 1ns/1ns
`default_nettype none

`include "usb_stream_params.svh"

module packet_streamer
  import usb_stream_pkg::*;
(
  input  wire         ulpi_clk,       // Single clock domain
  input  wire         I_rst_n,        // Async, active low
  input  wire fifo_count_t count_i,   // FIFO fill in bytes
  input  wire         usb_online_i,   // Link configured
  input  wire         usb_suspend_i,  // Link suspended
  input  wire         tx_pop_i,       // Controller takes a byte
  output logic        tx_valid_o,     // Packet offered
  output logic        tx_cork_o,      // Not enough data yet
  output logic        fifo_rd_en_o    // Advance FIFO head
);

  // ==================================================
  // Constants
  // ==================================================
  localparam int POP_W = $clog2(`PKT_LEN);
  localparam fifo_count_t PKT_LEN_C = fifo_count_t'(`PKT_LEN);
  localparam logic [POP_W-1:0] LAST_POP = POP_W'(`PKT_LEN - 1);

  stream_state_t    state_q;          // Packet FSM
  logic [POP_W-1:0] pop_cnt_q;        // Bytes sent in this packet
  logic             pkt_ready;        // Full packet buffered
  logic             pop_ok;           // Pop that counts

  assign pkt_ready = count_i >= PKT_LEN_C;

  // ==================================================
  // Offer and cork
  // ==================================================
  // Once started, a packet runs to the end regardless of link flags
  always_comb begin
    case (state_q)
      STREAM_SEND: begin
        tx_valid_o = 1'b1;            // Hold offer through packet
        tx_cork_o = 1'b0;
      end
      default: begin
        tx_valid_o = pkt_ready && usb_online_i && !usb_suspend_i;
        tx_cork_o = !pkt_ready;       // Corked below one packet
      end
    endcase
  end

  // Pops outside an offer are ignored
  assign pop_ok = tx_pop_i && tx_valid_o;
  assign fifo_rd_en_o = pop_ok;

  // ==================================================
  // FSM and pop counter
  // ==================================================
  always_ff @(posedge ulpi_clk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      state_q <= STREAM_IDLE;
      pop_cnt_q <= '0;
    end else if (pop_ok) begin
      pop_cnt_q <= pop_cnt_q + POP_W'(1);   // Wraps to 0 after last byte
      if (pop_cnt_q == LAST_POP) begin
        state_q <= STREAM_IDLE;             // Packet done, same edge
      end else begin
        state_q <= STREAM_SEND;             // First or middle byte
      end
    end
  end

  // ==================================================
  // Checks
  // ==================================================
  // Offer rule guarantees a full packet is buffered before any pop
  a_no_pop_empty: assert property (
    @(posedge ulpi_clk) disable iff (!I_rst_n)
    fifo_rd_en_o |-> (count_i != '0)
  ) else $error("Pop passed to empty FIFO");

endmodule

`default_nettype wire

/* hw/status_indicator.sv */
`timescale 1ns/1ns
`default_nettype none

`include "usb_stream_params.svh"

module status_indicator
  import usb_stream_pkg::*;
#(
  parameter int unsigned HALF_PERIOD = `HEARTBEAT_HALF_PERIOD  // Cycles per level
) (
  input  wire        ulpi_clk,        // Single clock domain
  input  wire        I_rst_n,         // Async, active low
  input  wire        usb_online_i,    // Link configured
  input  wire        usb_reset_i,     // Bus reset seen
  input  wire        usb_suspend_i,   // Link suspended
  output logic [3:0] led_o,           // Board LEDs, active low
  output logic       heartbeat_o      // Square wave to PMOD
);

  localparam logic [31:0] LAST_CNT = 32'(HALF_PERIOD - 1);

  logic [31:0] cnt_q;                 // Cycle counter
  logic        beat_q;                // Heartbeat level

  // ==================================================
  // Heartbeat divider
  // ==================================================
  always_ff @(posedge ulpi_clk or negedge I_rst_n) begin
    if (!I_rst_n) begin
      cnt_q <= '0;
      beat_q <= 1'b0;                 // Starts low
    end else if (cnt_q >= LAST_CNT) begin
      cnt_q <= '0;
      beat_q <= ~beat_q;              // Toggle each half period
    end else begin
      cnt_q <= cnt_q + 32'd1;
    end
  end

  assign heartbeat_o = beat_q;

  // ==================================================
  // LEDs
  // ==================================================
  // LED lit when the condition is true
  assign led_o[0] = ~usb_online_i;    // Connected
  assign led_o[1] = ~usb_reset_i;     // Bus reset
  assign led_o[2] = ~usb_suspend_i;   // Suspended
  assign led_o[3] = I_rst_n;          // Dark while in reset

endmodule

`default_nettype wire

/* hw/usb_stream_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "usb_stream_params.svh"

module usb_stream_top
  import usb_stream_pkg::*;
#(
  parameter int unsigned HALF_PERIOD = `HEARTBEAT_HALF_PERIOD  // Heartbeat half period
) (
  input  wire         ulpi_clk,       // 60 MHz from PHY
  input  wire         I_rst_n,        // Async, active low
  // Camera side
  input  wire         pixel_valid_i,  // Pixel strobe
  input  wire pixel_t pixel_data_i,   // RGB565 word
  // Link status from device controller
  input  wire         usb_online_i,
  input  wire         usb_reset_i,
  input  wire         usb_suspend_i,
  // Bulk transmit handshake
  input  wire         tx_pop_i,       // Controller takes a byte
  output byte_t       tx_data_o,      // Head byte
  output logic        tx_valid_o,     // Packet offered
  output logic        tx_cork_o,      // Under one packet buffered
  // ULPI data bus
  input  wire         ulpi_dir_i,     // PHY owns the bus when high
  input  wire byte_t  ulpi_tx_data_i, // Link to PHY
  output byte_t       ulpi_rx_data_o, // PHY to link
  inout  wire byte_t  ulpi_data_io,   // Shared pins
  output logic        ulpi_rst_o,     // PHY reset
  // Board indicators
  output logic [3:0]  led_o,
  output logic        heartbeat_o
);

  // ==================================================
  // Internal nets
  // ==================================================
  fifo_count_t fifo_count;            // Bytes buffered
  logic        fifo_almost_full;      // No room for a pixel
  logic        fifo_rd_en;            // Accepted pop
  logic        pixel_wr_en;           // Gated pixel strobe

  assign pixel_wr_en = pixel_valid_i & ~fifo_almost_full;  // Drop when full

  // Pixel to byte buffering
  pixel_byte_fifo u_fifo (
    .ulpi_clk      (ulpi_clk),
    .I_rst_n       (I_rst_n),
    .wr_en_i       (pixel_wr_en),
    .wr_data_i     (pixel_data_i),
    .rd_en_i       (fifo_rd_en),
    .rd_data_o     (tx_data_o),       // FWFT head straight out
    .count_o       (fifo_count),
    .almost_full_o (fifo_almost_full)
  );

  // Packet offer and pop gating
  packet_streamer u_streamer (
    .ulpi_clk      (ulpi_clk),
    .I_rst_n       (I_rst_n),
    .count_i       (fifo_count),
    .usb_online_i  (usb_online_i),
    .usb_suspend_i (usb_suspend_i),
    .tx_pop_i      (tx_pop_i),
    .tx_valid_o    (tx_valid_o),
    .tx_cork_o     (tx_cork_o),
    .fifo_rd_en_o  (fifo_rd_en)
  );

  // LEDs and heartbeat
  status_indicator #(
    .HALF_PERIOD (HALF_PERIOD)
  ) u_status (
    .ulpi_clk      (ulpi_clk),
    .I_rst_n       (I_rst_n),
    .usb_online_i  (usb_online_i),
    .usb_reset_i   (usb_reset_i),
    .usb_suspend_i (usb_suspend_i),
    .led_o         (led_o),
    .heartbeat_o   (heartbeat_o)
  );

  // ==================================================
  // ULPI bus turnaround
  // ==================================================
  assign ulpi_data_io = ulpi_dir_i ? 'z : ulpi_tx_data_i;  // Drive only when we own it
  assign ulpi_rx_data_o = ulpi_data_io;                     // Always sampled
  assign ulpi_rst_o = 1'b1;                                 // PHY kept out of reset

endmodule

`default_nettype wire

/* sim/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ==================================================
// Failure reporting
// ==================================================
int checks_run = 0;                   // Checks evaluated so far

// Stops the run at the first problem
task automatic report_failure(input string why);
  $display("%s", why);                // Cause in plain words
  $display("** FAIL **");
  $fatal(1, "Stopped at %0t ns", $time);
endtask

// ==================================================
// Typed compares
// ==================================================
task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
  checks_run++;
  if (actual !== expected) begin
    report_failure($sformatf("CHECK FAILED %s expected 0x%h actual 0x%h",
                             name, expected, actual));
  end
endtask

task automatic check_flag(input string name, input logic expected, input logic actual);
  checks_run++;
  if (actual !== expected) begin
    report_failure($sformatf("CHECK FAILED %s expected 0x%h actual 0x%h",
                             name, expected, actual));
  end
endtask

// Counts and measured intervals
task automatic check_count(input string name, input int expected, input int actual);
  checks_run++;
  if (actual !== expected) begin
    report_failure($sformatf("CHECK FAILED %s expected 0x%h actual 0x%h",
                             name, expected, actual));
  end
endtask

`endif

/* sim/tb_usb_stream.sv */
`timescale 1ns/1ns
`default_nettype none

`include "usb_stream_params.svh"

module tb_usb_stream
  import usb_stream_pkg::*;
;

  localparam int CLK_HALF_NS = 50;    // 100 ns period
  localparam int SKEW_NS = 5;         // Drive delay after rising edge
  localparam int RESET_CYCLES = 10;
  localparam int HB_HALF = 20;        // Heartbeat override
  localparam int SEED = 57741;
  localparam int MAX_RECORDS = 16;
  localparam int REC_FIELDS = 8;      // Words per stimulus record

  logic   ulpi_clk = 1'b0;
  logic   I_rst_n;
  logic   pixel_valid;
  logic   tx_pop;
  logic   ulpi_dir;
  logic   usb_online;
  logic   usb_reset;
  logic   usb_suspend;
  pixel_t pixel_data;
  byte_t  ulpi_tx_data;
  byte_t  ulpi_rx_data;
  byte_t  tx_data;
  byte_t  bus_drive_val;
  logic   bus_drive_en;               // TB plays the PHY on the bus
  wire byte_t ulpi_bus;
  logic   tx_valid;
  logic   tx_cork;
  logic   ulpi_rst;
  logic   heartbeat;
  logic [3:0] led;

  // ==================================================
  // Scoreboard state
  // ==================================================
  byte_t       exp_q[$];              // Bytes the FIFO should hold
  int          pkt_pops = 0;          // Pops inside the open packet
  int          pkts_done = 0;
  logic        online_lvl = 1'b0;
  logic        suspend_lvl = 1'b0;
  logic [31:0] stim_mem [MAX_RECORDS*REC_FIELDS];
  longint      limit_ns;
  logic        limit_ready = 1'b0;

  `include "tb_checks.svh"

  assign ulpi_bus = bus_drive_en ? bus_drive_val : 'z;

  usb_stream_top #(.HALF_PERIOD(HB_HALF)) uut (
    .ulpi_clk(ulpi_clk), .I_rst_n(I_rst_n),
    .pixel_valid_i(pixel_valid), .pixel_data_i(pixel_data),
    .usb_online_i(usb_online), .usb_reset_i(usb_reset), .usb_suspend_i(usb_suspend),
    .tx_pop_i(tx_pop), .tx_data_o(tx_data), .tx_valid_o(tx_valid), .tx_cork_o(tx_cork),
    .ulpi_dir_i(ulpi_dir), .ulpi_tx_data_i(ulpi_tx_data), .ulpi_rx_data_o(ulpi_rx_data),
    .ulpi_data_io(ulpi_bus), .ulpi_rst_o(ulpi_rst), .led_o(led), .heartbeat_o(heartbeat)
  );

  always #CLK_HALF_NS ulpi_clk = ~ulpi_clk;

  // Offer rule from the packet state and buffered bytes
  function automatic logic offer_expected();
    return (pkt_pops != 0) || (exp_q.size() >= `PKT_LEN && online_lvl && !suspend_lvl);
  endfunction

  task automatic compare_leds();
    check_flag("led_o[0]", ~usb_online, led[0]);    // Active low
    check_flag("led_o[1]", ~usb_reset, led[1]);
    check_flag("led_o[2]", ~usb_suspend, led[2]);
    check_flag("led_o[3]", I_rst_n, led[3]);
  endtask

  // Drive after the edge, check at the falling edge, then model the next edge
  task automatic step_cycle(input logic pix_v, input pixel_t pix_d, input logic pop);
    logic offer;
    logic accept;
    @(posedge ulpi_clk);
    #SKEW_NS;
    pixel_valid = pix_v;
    pixel_data = pix_d;
    tx_pop = pop;
    usb_online = online_lvl;
    usb_suspend = suspend_lvl;
    @(negedge ulpi_clk);
    offer = offer_expected();
    check_flag("tx_valid_o", offer, tx_valid);
    check_flag("tx_cork_o", (pkt_pops == 0) && (exp_q.size() < `PKT_LEN), tx_cork);
    if (exp_q.size() != 0) begin
      check_byte("tx_data_o", exp_q[0], tx_data);  // FWFT head
    end
    compare_leds();
    accept = pix_v && (exp_q.size() <= `FIFO_DEPTH_BYTES - 2);  // Room before the edge
    if (pop && offer) begin
      void'(exp_q.pop_front());
      pkt_pops++;
      if (pkt_pops == `PKT_LEN) begin
        pkt_pops = 0;                 // Packet closes on this edge
        pkts_done++;
      end
    end
    if (accept) begin
      exp_q.push_back(pix_d[`PIXEL_W-1 -: `BYTE_W]);  // High byte first
      exp_q.push_back(pix_d[`BYTE_W-1:0]);
    end
  endtask

  // ==================================================
  // Record runner
  // ==================================================
  task automatic run_record(input int base);
    int     n_pix;
    int     susp_mode;
    int     exp_pkts;
    int     start_pkts;
    pixel_t pix;
    pixel_t inc;
    logic   pops_on;
    n_pix = stim_mem[base+1];
    pix = pixel_t'(stim_mem[base+2]);
    inc = pixel_t'(stim_mem[base+3]);
    online_lvl = stim_mem[base+4][0];
    susp_mode = stim_mem[base+5];
    suspend_lvl = (susp_mode == 1);   // Mode 2 starts low
    pops_on = stim_mem[base+6][0];
    exp_pkts = stim_mem[base+7];
    start_pkts = pkts_done;
    $display("Test %0d: %0d pixels, online %0d, suspend mode %0d, pops %0d",
             stim_mem[base], n_pix, online_lvl, susp_mode, pops_on);
    repeat (2) step_cycle(1'b0, '0, 1'b0);          // Flags settle
    for (int i = 0; i < n_pix; i++) begin
      step_cycle(1'b1, pix, 1'b0);
      pix = pix + inc;
    end
    step_cycle(1'b0, '0, 1'b0);                     // Last pixel lands
    if (pops_on) begin
      while (offer_expected()) begin
        if (susp_mode == 2 && pkt_pops == `PKT_LEN / 2) begin
          suspend_lvl = 1'b1;         // Mid-packet suspend
        end
        step_cycle(1'b0, '0, ($urandom % 3) != 0);  // Random pop gaps
      end
      repeat (3) step_cycle(1'b0, '0, 1'b1);        // Pops with no offer
    end
    check_count("packets completed", exp_pkts, pkts_done - start_pkts);
  endtask

  task automatic test_ulpi_bus();
    byte_t val;
    for (int k = 0; k < 4; k++) begin
      val = byte_t'($urandom);
      @(posedge ulpi_clk);
      #SKEW_NS;
      bus_drive_en = 1'b0;
      ulpi_dir = 1'b0;                // Link owns the bus
      ulpi_tx_data = val;
      usb_reset = k[0];
      @(negedge ulpi_clk);
      check_byte("ulpi_data_io", val, ulpi_bus);
      check_byte("ulpi_rx_data_o", val, ulpi_rx_data);
      compare_leds();
      @(posedge ulpi_clk);
      #SKEW_NS;
      ulpi_dir = 1'b1;                // PHY turns the bus around
      bus_drive_val = byte_t'(~val);
      bus_drive_en = 1'b1;
      @(negedge ulpi_clk);
      check_byte("ulpi_rx_data_o", byte_t'(~val), ulpi_rx_data);
      check_flag("ulpi_rst_o", 1'b1, ulpi_rst);
    end
    bus_drive_en = 1'b0;
    ulpi_dir = 1'b0;
  endtask

  // Cycles between two heartbeat edges
  task automatic measure_heartbeat();
    logic level;
    int   n;
    @(negedge ulpi_clk);
    level = heartbeat;
    while (heartbeat === level) @(negedge ulpi_clk);
    level = heartbeat;
    n = 0;
    while (heartbeat === level) begin
      @(negedge ulpi_clk);
      n++;
    end
    check_count("heartbeat_o half period", HB_HALF, n);
  endtask

  // ==================================================
  // Watchdog
  // ==================================================
  initial begin
    wait (limit_ready === 1'b1);
    #(limit_ns);
    report_failure("Watchdog timeout: the run did not finish in the allowed time");
  end

  initial begin
    int base;
    int total_cycles;
    I_rst_n = 1'b0;
    pixel_valid = 1'b0;
    pixel_data = '0;
    usb_online = 1'b0;
    usb_reset = 1'b0;
    usb_suspend = 1'b0;
    tx_pop = 1'b0;
    ulpi_dir = 1'b0;
    ulpi_tx_data = '0;
    bus_drive_val = '0;
    bus_drive_en = 1'b0;
    void'($urandom(SEED));
    $readmemh("sim/usb_stream_stimulus.txt", stim_mem);
    total_cycles = 200;               // Reset, bus and heartbeat phases
    base = 0;
    while (base < MAX_RECORDS * REC_FIELDS && stim_mem[base] != 0) begin
      total_cycles += stim_mem[base+1] + stim_mem[base+7] * `PKT_LEN + 8;
      base += REC_FIELDS;
    end
    if (base == 0) begin
      report_failure("No test records were read from the stimulus file");
    end
    limit_ns = longint'(total_cycles) * 4 * 100;
    limit_ready = 1'b1;
    repeat (RESET_CYCLES) @(posedge ulpi_clk);
    #SKEW_NS;
    I_rst_n = 1'b1;
    @(negedge ulpi_clk);
    check_flag("tx_valid_o", 1'b0, tx_valid);       // Reset state
    check_flag("tx_cork_o", 1'b1, tx_cork);
    check_flag("heartbeat_o", 1'b0, heartbeat);
    compare_leds();
    base = 0;
    while (base < MAX_RECORDS * REC_FIELDS && stim_mem[base] != 0) begin
      run_record(base);
      base += REC_FIELDS;
    end
    test_ulpi_bus();
    measure_heartbeat();
    $display("%0d checks done", checks_run);
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

/* sim/usb_stream_stimulus.txt */
// Columns (hex): test pixels start incr online suspend pops packets
// Suspend: 0 off, 1 held for the record, 2 raised in the middle of the first packet
// Threshold: 255 pixels stay below one packet
1 FF 0100 0001 1 0 0 0
// The 256th pixel raises the offer
2 1 01FF 0001 1 0 0 0
// Suspend and offline hold the offer back
3 0 0000 0000 1 1 0 0
4 0 0000 0000 0 0 1 0
// Packet survives a suspend raised mid-packet
5 0 0000 0000 1 2 1 1
// Overflow: 700 pixels, the first 512 are kept
6 2BC 8000 0101 1 0 0 0
7 0 0000 0000 1 0 1 2
// Mixed fill levels across packets
8 12C FFF0 0007 1 0 1 1
9 D4 1234 0F0F 1 0 1 1
// End of records
0 0 0000 0000 0 0 0 0

/* sources.f */
+incdir+hw
+incdir+sim
hw/usb_stream_pkg.sv
hw/pixel_byte_fifo.sv
hw/packet_streamer.sv
hw/status_indicator.sv
hw/usb_stream_top.sv
sim/tb_usb_stream.sv
